// File: files.f
rtl/alu_pkg.sv
rtl/alu_adder.sv
rtl/alu_logic.sv
rtl/alu_decode.sv
rtl/alu_result_stage.sv
rtl/alu_top.sv
tb/alu_asserts.sv
tb/alu_tb.sv

// File: rtl/alu_adder.sv
module alu_adder (
  input  alu_pkg::reg_t   a,
  input  alu_pkg::reg_t   b,
  input  logic            carry_in,
  input  alu_pkg::width_e width,
  output alu_pkg::reg_t   sum,
  output logic            carry_out,
  output logic            overflow
);
  import alu_pkg::*;

  logic [REG_W:0] full_sum;
  logic [REG_W:0] carries;
  int unsigned    msb;

  assign full_sum = {1'b0, a} + {1'b0, b} + {{REG_W{1'b0}}, carry_in};

  // Bit i of carries is the carry into bit i of the full-width sum.
  assign carries = full_sum ^ {1'b0, a} ^ {1'b0, b};

  assign msb = width_bits(width) - 1;

  assign carry_out = carries[msb+1];

  // Signed overflow when the carry into the sign bit differs from the carry out of it.
  assign overflow = carries[msb+1] ^ carries[msb];

  assign sum = full_sum[REG_W-1:0] & width_mask(width);

endmodule

// File: rtl/alu_decode.sv
module alu_decode (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  output logic                in_ready,
  input  alu_pkg::opcode_e    opcode,
  input  alu_pkg::reg_t       s,
  input  alu_pkg::reg_t       t,
  input  alu_pkg::imm_t       imm,
  input  alu_pkg::width_e     width,
  input  alu_pkg::flags_t     flags_in,
  input  logic                s1_ready,
  output logic                s1_valid,
  output alu_pkg::op_class_e  op_class,
  output alu_pkg::reg_t       a,
  output alu_pkg::reg_t       b,
  output logic                carry_in,
  output logic                invert_carry,
  output logic                write_en_d,
  output alu_pkg::width_e     width_d,
  output alu_pkg::flags_t     flags_d
);
  import alu_pkg::*;

  op_class_e cls;
  reg_t      b_src;
  logic      is_imm;
  logic      is_sub;
  logic      cin;
  logic      wen;
  logic      cf;

  assign cf       = flags_in[FLAG_CF];
  assign in_ready = !s1_valid || s1_ready;

  // ========================================
  // Decode
  // ========================================
  always_comb begin
    case (opcode)
      ADD, ADDI, ADC, ADCI, SUB, SUBI, SBB, SBBI, CMP, CMPI: cls = CLS_ARITH;
      AND, ANDI, TEST, TESTI: cls = CLS_AND;
      OR, ORI:                cls = CLS_OR;
      XOR, XORI:              cls = CLS_XOR;
      SLLI:                   cls = CLS_SHL;
      MOV, MOVI:              cls = CLS_MOV;
      default:                cls = CLS_NONE;
    endcase
  end

  assign is_imm = opcode inside {ADDI, SUBI, ADCI, SBBI, ANDI, ORI, XORI,
                                 SLLI, MOVI, CMPI, TESTI};
  assign is_sub = opcode inside {SUB, SUBI, SBB, SBBI, CMP, CMPI};
  assign wen    = (cls != CLS_NONE) && !(opcode inside {CMP, CMPI, TEST, TESTI});

  // Subtraction is a + ~b + 1, so a borrow-in of CF becomes a carry-in of ~CF.
  always_comb begin
    case (opcode)
      SUB, SUBI, CMP, CMPI: cin = 1'b1;
      SBB, SBBI:            cin = ~cf;
      ADC, ADCI:            cin = cf;
      default:              cin = 1'b0;
    endcase
  end

  assign b_src = is_imm ? {{(REG_W-IMM_W){imm[IMM_W-1]}}, imm} : t;

  // ========================================
  // Stage 1 register
  // ========================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else if (in_ready) begin
      s1_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      op_class     <= cls;
      a            <= s;
      b            <= is_sub ? ~b_src : b_src;
      carry_in     <= cin;
      invert_carry <= is_sub;
      write_en_d   <= wen;
      width_d      <= width;
      flags_d      <= flags_in;
    end
  end

endmodule

// File: rtl/alu_logic.sv
module alu_logic (
  input  alu_pkg::op_class_e op_class,
  input  alu_pkg::reg_t      a,
  input  alu_pkg::reg_t      b,
  input  alu_pkg::width_e    width,
  output alu_pkg::reg_t      logic_result
);
  import alu_pkg::*;

  reg_t raw;

  always_comb begin
    case (op_class)
      CLS_AND: raw = a & b;
      CLS_OR:  raw = a | b;
      CLS_XOR: raw = a ^ b;
      CLS_SHL: raw = a << b[SHIFT_W-1:0];
      CLS_MOV: raw = b;
      default: raw = '0;
    endcase
  end

  // Bits shifted past the operand width are dropped here.
  assign logic_result = raw & width_mask(width);

endmodule

// File: rtl/alu_pkg.sv
package alu_pkg;

  localparam int REG_W   = 64;
  localparam int IMM_W   = 32;
  localparam int SHIFT_W = 6;

  typedef logic [REG_W-1:0] reg_t;
  typedef logic [IMM_W-1:0] imm_t;
  typedef logic [REG_W-1:0] flags_t;

  // Bit positions in the flags word follow the x86 EFLAGS layout.
  localparam int FLAG_CF = 0;
  localparam int FLAG_PF = 2;
  localparam int FLAG_AF = 4;
  localparam int FLAG_ZF = 6;
  localparam int FLAG_SF = 7;
  localparam int FLAG_OF = 11;

  // Codes 21 to 31 are undefined.
  typedef enum logic [4:0] {
    ADD, ADDI, SUB, SUBI, ADC, ADCI, SBB, SBBI,
    AND, ANDI, OR, ORI, XOR, XORI,
    SLLI,
    MOV, MOVI,
    CMP, CMPI, TEST, TESTI
  } opcode_e;

  typedef enum logic [1:0] {
    W8, W16, W32, W64
  } width_e;

  typedef enum logic [2:0] {
    CLS_ARITH, CLS_AND, CLS_OR, CLS_XOR, CLS_SHL, CLS_MOV, CLS_NONE
  } op_class_e;

  function automatic int unsigned width_bits(width_e w);
    case (w)
      W8:      return 8;
      W16:     return 16;
      W32:     return 32;
      default: return REG_W;
    endcase
  endfunction

  function automatic reg_t width_mask(width_e w);
    case (w)
      W8:      return 64'h0000_0000_0000_00ff;
      W16:     return 64'h0000_0000_0000_ffff;
      W32:     return 64'h0000_0000_ffff_ffff;
      default: return '1;
    endcase
  endfunction

endpackage

// File: rtl/alu_result_stage.sv
module alu_result_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                s1_valid,
  output logic                s1_ready,
  input  alu_pkg::op_class_e  op_class,
  input  alu_pkg::reg_t       sum,
  input  logic                carry_out,
  input  logic                overflow,
  input  logic                invert_carry,
  input  alu_pkg::reg_t       logic_result,
  input  logic                write_en_d,
  input  alu_pkg::width_e     width_d,
  input  alu_pkg::flags_t     flags_d,
  output logic                out_valid,
  input  logic                out_ready,
  output alu_pkg::reg_t       result,
  output logic                write_en,
  output alu_pkg::flags_t     flags_out
);
  import alu_pkg::*;

  reg_t   res;
  logic   sign;
  logic   zero;
  logic   parity;
  flags_t flags_next;

  assign s1_ready = !out_valid || out_ready;

  // ========================================
  // Result and flags
  // ========================================
  assign res    = (op_class == CLS_ARITH) ? sum : logic_result;
  assign sign   = res[width_bits(width_d)-1];
  assign zero   = (res == '0);
  assign parity = ~^res;

  always_comb begin
    flags_next = flags_d;
    case (op_class)
      CLS_ARITH: begin
        flags_next[FLAG_OF] = overflow;
        flags_next[FLAG_CF] = carry_out ^ invert_carry;
        flags_next[FLAG_SF] = sign;
        flags_next[FLAG_ZF] = zero;
        flags_next[FLAG_PF] = parity;
        flags_next[FLAG_AF] = 1'b0;
      end
      CLS_AND, CLS_OR, CLS_XOR, CLS_SHL: begin
        flags_next[FLAG_OF] = 1'b0;
        flags_next[FLAG_CF] = 1'b0;
        flags_next[FLAG_SF] = sign;
        flags_next[FLAG_ZF] = zero;
        flags_next[FLAG_PF] = parity;
        flags_next[FLAG_AF] = 1'b0;
      end
      default: begin
        // MOV and undefined opcodes keep the incoming flags.
        flags_next = flags_d;
      end
    endcase
  end

  // ========================================
  // Output register
  // ========================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (s1_ready) begin
      out_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid && s1_ready) begin
      result    <= write_en_d ? res : '0;
      write_en  <= write_en_d;
      flags_out <= flags_next;
    end
  end

endmodule

// File: rtl/alu_top.sv
module alu_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid,
  output logic               in_ready,
  input  alu_pkg::opcode_e   opcode,
  input  alu_pkg::reg_t      s,
  input  alu_pkg::reg_t      t,
  input  alu_pkg::imm_t      imm,
  input  alu_pkg::width_e    width,
  input  alu_pkg::flags_t    flags_in,
  output logic               out_valid,
  input  logic               out_ready,
  output alu_pkg::reg_t      result,
  output logic               write_en,
  output alu_pkg::flags_t    flags_out
);
  import alu_pkg::*;

  logic      s1_valid;
  logic      s1_ready;
  op_class_e op_class;
  reg_t      a;
  reg_t      b;
  logic      carry_in;
  logic      invert_carry;
  logic      write_en_d;
  width_e    width_d;
  flags_t    flags_d;
  reg_t      sum;
  logic      carry_out;
  logic      overflow;
  reg_t      logic_result;

  alu_decode u_decode (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .opcode       (opcode),
    .s            (s),
    .t            (t),
    .imm          (imm),
    .width        (width),
    .flags_in     (flags_in),
    .s1_ready     (s1_ready),
    .s1_valid     (s1_valid),
    .op_class     (op_class),
    .a            (a),
    .b            (b),
    .carry_in     (carry_in),
    .invert_carry (invert_carry),
    .write_en_d   (write_en_d),
    .width_d      (width_d),
    .flags_d      (flags_d)
  );

  alu_adder u_adder (
    .a         (a),
    .b         (b),
    .carry_in  (carry_in),
    .width     (width_d),
    .sum       (sum),
    .carry_out (carry_out),
    .overflow  (overflow)
  );

  alu_logic u_logic (
    .op_class     (op_class),
    .a            (a),
    .b            (b),
    .width        (width_d),
    .logic_result (logic_result)
  );

  alu_result_stage u_result (
    .clk          (clk),
    .rst_n        (rst_n),
    .s1_valid     (s1_valid),
    .s1_ready     (s1_ready),
    .op_class     (op_class),
    .sum          (sum),
    .carry_out    (carry_out),
    .overflow     (overflow),
    .invert_carry (invert_carry),
    .logic_result (logic_result),
    .write_en_d   (write_en_d),
    .width_d      (width_d),
    .flags_d      (flags_d),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .result       (result),
    .write_en     (write_en),
    .flags_out    (flags_out)
  );

endmodule

// File: tb/alu_asserts.sv
module alu_asserts (
  input logic               clk,
  input logic               rst_n,
  input logic               s1_valid,
  input logic               s1_ready,
  input alu_pkg::op_class_e op_class,
  input logic               out_valid,
  input logic               out_ready,
  input alu_pkg::reg_t      result,
  input logic               write_en,
  input alu_pkg::flags_t    flags_out
);
  timeunit 1ns;
  timeprecision 1ps;
  import alu_pkg::*;

  int        fail_count = 0;
  op_class_e out_class;

  // Class of the operation held in the output register.
  always_ff @(posedge clk) begin
    if (s1_valid && s1_ready) begin
      out_class <= op_class;
    end
  end

  reset_clears_valid: assert property (@(posedge clk) !rst_n |=> !out_valid)
    else begin
      $error("out_valid is high in the cycle after reset");
      fail_count++;
    end

  hold_while_stalled: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && !out_ready |=> out_valid && $stable(result) && $stable(write_en)
                                  && $stable(flags_out))
    else begin
      $error("outputs changed while the sink stalled");
      fail_count++;
    end

  af_cleared: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && !(out_class inside {CLS_MOV, CLS_NONE}) |-> !flags_out[FLAG_AF])
    else begin
      $error("AF set on an arithmetic or logic result");
      fail_count++;
    end

endmodule

bind alu_top alu_asserts u_asserts (.*);

// File: tb/alu_tb.sv
module alu_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import alu_pkg::*;

  // About 550 operations take up to three cycles each while the sink stalls.
  localparam int MAX_CYCLES = 3000;

  logic    clk = 1'b0;
  logic    rst_n;
  logic    in_valid;
  logic    in_ready;
  opcode_e opcode;
  reg_t    s;
  reg_t    t;
  imm_t    imm;
  width_e  width;
  flags_t  flags_in;
  logic    out_valid;
  logic    out_ready;
  reg_t    result;
  logic    write_en;
  flags_t  flags_out;

  integer  seed = 32'h1eec_91ff;
  int      cycles = 0;
  string   cur_test = "init";
  reg_t    exp_res_q[$];
  logic    exp_wen_q[$];
  flags_t  exp_flags_q[$];

  alu_top UUT (.*);

  always #20 clk = ~clk;

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic check_result(input reg_t exp, input reg_t act);
    if (act !== exp)
      fail_stop($sformatf("CHECK FAILED %s result: expected %h, actual %h", cur_test, exp, act));
  endtask

  task automatic check_flags(input flags_t exp, input flags_t act);
    if (act !== exp)
      fail_stop($sformatf("CHECK FAILED %s flags: expected %h, actual %h", cur_test, exp, act));
  endtask

  task automatic check_write(input logic exp, input logic act);
    if (act !== exp)
      fail_stop($sformatf("CHECK FAILED %s write_en: expected %b, actual %b", cur_test, exp, act));
  endtask

  task automatic check_ctrl(input string name, input logic exp, input logic act);
    if (act !== exp)
      fail_stop($sformatf("CHECK FAILED %s %s: expected %b, actual %b",
                          cur_test, name, exp, act));
  endtask

  // ========================================
  // Reference model
  // ========================================
  function automatic logic signed [65:0] sext(input reg_t v, input int n);
    logic signed [65:0] r;
    r = $signed({2'b00, v});
    if (v[n-1])
      r = r - (66'sd1 <<< n);
    return r;
  endfunction

  function automatic void model(input opcode_e op, input reg_t sv, input reg_t tv,
                                input imm_t iv, input width_e w, input flags_t fin,
                                output reg_t res, output logic wen, output flags_t fo);
    int                 n;
    reg_t               mask;
    reg_t               bv;
    reg_t               sa;
    reg_t               sb;
    reg_t               r;
    logic               cin;
    logic               cf;
    logic               arith;
    logic               logical;
    logic signed [65:0] x;
    logic signed [65:0] lim;
    n    = 8 << w;
    mask = (n == REG_W) ? '1 : ((64'd1 << n) - 64'd1);
    bv   = (op inside {ADDI, SUBI, ADCI, SBBI, ANDI, ORI, XORI, SLLI, MOVI, CMPI, TESTI}) ?
           {{(REG_W-IMM_W){iv[IMM_W-1]}}, iv} : tv;
    sa   = sv & mask;
    sb   = bv & mask;
    cin  = (op inside {ADC, ADCI, SBB, SBBI}) ? fin[FLAG_CF] : 1'b0;
    lim  = 66'sd1 <<< (n - 1);
    arith   = op inside {ADD, ADDI, ADC, ADCI, SUB, SUBI, SBB, SBBI, CMP, CMPI};
    logical = op inside {AND, ANDI, OR, ORI, XOR, XORI, SLLI, TEST, TESTI};
    wen  = (arith || logical || op inside {MOV, MOVI}) && !(op inside {CMP, CMPI, TEST, TESTI});
    fo   = fin;
    r    = '0;
    // CF is the carry for additions and the borrow for subtractions.
    if (op inside {SUB, SUBI, SBB, SBBI, CMP, CMPI}) begin
      x  = sext(sa, n) - sext(sb, n) - cin;
      cf = {2'b00, sa} < ({2'b00, sb} + cin);
    end else begin
      x  = sext(sa, n) + sext(sb, n) + cin;
      cf = ({2'b00, sa} + {2'b00, sb} + cin) > {2'b00, mask};
    end
    case (op)
      AND, ANDI, TEST, TESTI: r = sv & bv;
      OR, ORI:                r = sv | bv;
      XOR, XORI:              r = sv ^ bv;
      SLLI:                   r = sv << bv[SHIFT_W-1:0];
      MOV, MOVI:              r = bv;
      default:                r = x[REG_W-1:0];
    endcase
    r = r & mask;
    if (arith || logical) begin
      fo[FLAG_OF] = arith && ((x >= lim) || (x < -lim));
      fo[FLAG_CF] = arith && cf;
      fo[FLAG_SF] = r[n-1];
      fo[FLAG_ZF] = (r == '0);
      fo[FLAG_PF] = ~^r;
      fo[FLAG_AF] = 1'b0;
    end
    res = wen ? r : '0;
  endfunction

  // ========================================
  // Driver and monitor
  // ========================================
  function automatic reg_t rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  // Called 2 ns after an edge; returns 2 ns after the accepting edge.
  task automatic issue(input opcode_e op, input reg_t sv, input reg_t tv, input width_e w,
                       input flags_t f);
    reg_t   e_res;
    logic   e_wen;
    flags_t e_flags;
    model(op, sv, tv, tv[IMM_W-1:0], w, f, e_res, e_wen, e_flags);
    in_valid = 1'b1;
    opcode   = op;
    s        = sv;
    t        = tv;
    imm      = tv[IMM_W-1:0];
    width    = w;
    flags_in = f;
    @(posedge clk);
    while (!in_ready)
      @(posedge clk);
    exp_res_q.push_back(e_res);
    exp_wen_q.push_back(e_wen);
    exp_flags_q.push_back(e_flags);
    #2;
    in_valid = 1'b0;
  endtask

  task automatic drain();
    while (exp_res_q.size() != 0) begin
      @(posedge clk);
      #2;
    end
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES)
      fail_stop($sformatf("Timeout: the run did not finish within %0d cycles", MAX_CYCLES));
    if (UUT.u_asserts.fail_count != 0)
      fail_stop($sformatf("%s: a bound assertion on the handshake or flags failed", cur_test));
    if (rst_n && out_valid && out_ready) begin
      if (exp_res_q.size() == 0)
        fail_stop($sformatf("%s: an output appeared with no operation pending", cur_test));
      else begin
        check_result(exp_res_q.pop_front(), result);
        check_write(exp_wen_q.pop_front(), write_en);
        check_flags(exp_flags_q.pop_front(), flags_out);
      end
    end
  end

  // ========================================
  // Tests
  // ========================================
  task automatic test_reset();
    cur_test = "reset";
    check_ctrl("out_valid", 1'b0, out_valid);
    check_ctrl("in_ready", 1'b1, in_ready);
    issue(ADD, 64'd5, 64'd7, W32, '0);
    @(posedge clk);
    check_ctrl("out_valid", 1'b0, out_valid);
    @(posedge clk);
    check_ctrl("out_valid", 1'b1, out_valid);
    #2;
    drain();
  endtask

  task automatic test_arith();
    opcode_e ops [7] = '{ADD, ADDI, ADC, SUB, SUBI, SBB, CMP};
    reg_t    mask;
    reg_t    hi;
    reg_t    sv;
    reg_t    tv;
    cur_test = "arith";
    for (int wi = 0; wi < 4; wi++) begin
      mask = (wi == 3) ? '1 : ((64'd1 << (8 << wi)) - 64'd1);
      foreach (ops[i]) begin
        for (int k = 0; k < 8; k++) begin
          // Bits above the width must not leak into the result.
          hi = rand_word() & ~mask;
          sv = rand_word();
          tv = rand_word();
          case (k)
            0: sv = mask >> 1;
            1: sv = mask;
            2: sv = '0;
            3: sv = (mask >> 1) + 64'd1;
            4: tv = sv;
            default: ;
          endcase
          if (k < 4)
            tv = 64'd1;
          issue(ops[i], sv | hi, tv | hi, width_e'(wi), rand_word());
        end
      end
    end
    drain();
  endtask

  task automatic test_logic();
    opcode_e ops [9] = '{AND, ANDI, OR, ORI, XOR, XORI, SLLI, TEST, TESTI};
    reg_t    sv;
    cur_test = "logic";
    for (int wi = 0; wi < 4; wi++) begin
      foreach (ops[i]) begin
        for (int k = 0; k < 4; k++) begin
          sv = rand_word();
          issue(ops[i], sv, (k == 0) ? ~sv : rand_word(), width_e'(wi), rand_word());
        end
      end
    end
    drain();
  endtask

  task automatic test_passthrough();
    opcode_e ops [4] = '{MOV, MOVI, opcode_e'(5'd21), opcode_e'(5'd31)};
    cur_test = "passthrough";
    for (int wi = 0; wi < 4; wi++) begin
      foreach (ops[i]) begin
        issue(ops[i], rand_word(), rand_word(), width_e'(wi), rand_word());
        issue(ops[i], rand_word(), rand_word(), width_e'(wi), '1);
      end
    end
    drain();
  endtask

  task automatic test_backpressure();
    logic [127:0] ready_pat;
    bit           done;
    cur_test  = "backpressure";
    ready_pat = {rand_word(), rand_word()};
    done      = 1'b0;
    fork
      begin
        for (int i = 0; i < 150; i++)
          issue(opcode_e'(($random(seed) & 32'h7fff_ffff) % 23), rand_word(), rand_word(),
                width_e'($random(seed) & 3), rand_word());
        drain();
        done = 1'b1;
      end
      begin
        for (int c = 0; !done; c++) begin
          @(posedge clk);
          #2;
          out_ready = ready_pat[c % 128];
        end
        out_ready = 1'b1;
      end
    join
  endtask

  initial begin
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    opcode    = ADD;
    s         = '0;
    t         = '0;
    imm       = '0;
    width     = W8;
    flags_in  = '0;
    out_ready = 1'b1;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    test_reset();
    test_arith();
    test_logic();
    test_passthrough();
    test_backpressure();
    if (UUT.u_asserts.fail_count == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      fail_stop("A bound assertion on the handshake or flags failed at the end of the run");
    end
  end

endmodule
